//--- common/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data and address width
`define LSU_XLEN 32

// memory size in 32-bit words, a power of two
`define LSU_MEM_WORDS 256

// word index width into the banks
`define LSU_INDEX_W $clog2(`LSU_MEM_WORDS)

// bus response codes
`define LSU_RESP_OKAY   2'b00
`define LSU_RESP_SLVERR 2'b10

`endif

//--- common/lsu_pkg.sv
`include "lsu_macros.svh"

package lsu_pkg;

    typedef enum logic [3:0] {
        op_none,
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw
    } mem_op_e;

    // operation handed over by execute
    typedef struct packed {
        logic [`LSU_XLEN-1:0] pc;
        mem_op_e              op;
        logic [`LSU_XLEN-1:0] addr;
        logic [`LSU_XLEN-1:0] store_data;
        logic [4:0]           rd;
        logic                 reg_write;
    } exec_to_lsu_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0] pc;
        logic [4:0]           rd;
        logic                 reg_write;
        logic [`LSU_XLEN-1:0] result;
        logic                 fault;     // bus answered with an error
    } lsu_to_wb_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0]   data;
        logic [`LSU_XLEN/8-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0] data;
        logic [1:0]           resp;
    } axil_r_t;

    // write command for one byte bank
    typedef struct packed {
        logic [`LSU_INDEX_W-1:0] index;
        logic [7:0]              byte_data;
        logic                    enable;
    } lane_wr_t;

endpackage

//--- mem/mem_byte_lane.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module mem_byte_lane
    import lsu_pkg::*;
(
    input  logic                    clock,
    input  lane_wr_t                wr,
    input  logic [`LSU_INDEX_W-1:0] rd_index,
    output logic [7:0]              rd_byte
);

    logic [7:0] mem [`LSU_MEM_WORDS];

    always_ff @(posedge clock) begin
        if (wr.enable) mem[wr.index] <= wr.byte_data;
        rd_byte <= mem[rd_index];   // one cycle read
    end

endmodule

//--- mem/mem_write_port.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module mem_write_port
    import lsu_pkg::*;
(
    input  logic           clock,
    input  logic           reset,

    input  logic           awvalid,
    output logic           awready,
    input  axil_aw_t       aw,

    input  logic           wvalid,
    output logic           wready,
    input  axil_w_t        w,

    output logic           bvalid,
    input  logic           bready,
    output axil_b_t        b,

    output lane_wr_t [3:0] lane_wr
);

    logic                 aw_have;
    logic                 w_have;
    logic                 commit;       // one-cycle bank write pulse
    logic [`LSU_XLEN-1:0] addr_q;
    logic [`LSU_XLEN-1:0] data_q;
    logic [3:0]           strb_q;
    logic                 in_range;

    assign awready  = !aw_have && !bvalid;
    assign wready   = !w_have && !bvalid;
    assign in_range = (addr_q >> 2) < `LSU_MEM_WORDS;

    always_ff @(posedge clock) begin
        if (reset) begin
            aw_have <= 1'b0;
            w_have  <= 1'b0;
            commit  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            commit <= 1'b0;
            if (awvalid && awready) aw_have <= 1'b1;
            if (wvalid && wready)   w_have  <= 1'b1;
            if (aw_have && w_have) begin
                aw_have <= 1'b0;
                w_have  <= 1'b0;
                commit  <= 1'b1;
                bvalid  <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (awvalid && awready) addr_q <= aw.addr;
        if (wvalid && wready) begin
            data_q <= w.data;
            strb_q <= w.strb;
        end
    end

    // addr_q cannot change while B is pending
    assign b.resp = in_range ? `LSU_RESP_OKAY : `LSU_RESP_SLVERR;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lane_wr[i].index     = addr_q[2 +: `LSU_INDEX_W];
            lane_wr[i].byte_data = data_q[8*i +: 8];
            lane_wr[i].enable    = commit && in_range && strb_q[i];
        end
    end

endmodule

//--- mem/mem_read_port.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module mem_read_port
    import lsu_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,

    input  logic                    arvalid,
    output logic                    arready,
    input  axil_ar_t                ar,

    output logic                    rvalid,
    input  logic                    rready,
    output axil_r_t                 r,

    output logic [`LSU_INDEX_W-1:0] rd_index,
    input  logic [3:0][7:0]         lane_data
);

    logic                 fetch;        // banks reading this cycle
    logic [`LSU_XLEN-1:0] addr_q;
    logic                 in_range;

    assign arready  = !fetch && !rvalid;
    assign in_range = (addr_q >> 2) < `LSU_MEM_WORDS;
    assign rd_index = addr_q[2 +: `LSU_INDEX_W];

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch  <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (arvalid && arready) fetch <= 1'b1;
            if (fetch) begin
                fetch  <= 1'b0;
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (arvalid && arready) addr_q <= ar.addr;
    end

    // index is held, so bank outputs stay put while R waits
    assign r.data = in_range ? lane_data : '0;
    assign r.resp = in_range ? `LSU_RESP_OKAY : `LSU_RESP_SLVERR;

endmodule

//--- lsu/lsu_stage.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_stage
    import lsu_pkg::*;
(
    input  logic         clock,
    input  logic         reset,

    input  logic         in_valid,
    output logic         in_ready,
    input  exec_to_lsu_t in_data,

    output logic         out_valid,
    input  logic         out_ready,
    output lsu_to_wb_t   out_data,

    output logic         awvalid,
    input  logic         awready,
    output axil_aw_t     aw,

    output logic         wvalid,
    input  logic         wready,
    output axil_w_t      w,

    input  logic         bvalid,
    output logic         bready,
    input  axil_b_t      b,

    output logic         arvalid,
    input  logic         arready,
    output axil_ar_t     ar,

    input  logic         rvalid,
    output logic         rready,
    input  axil_r_t      r
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_write,
        st_wait_read,
        st_hold
    } state_e;

    state_e               state;
    exec_to_lsu_t         req;          // operation in flight
    logic [`LSU_XLEN-1:0] result_q;
    logic                 fault_q;
    logic                 aw_pend;
    logic                 w_pend;
    logic                 ar_pend;
    logic                 accept;
    logic                 in_is_load;
    logic                 in_is_store;
    logic [1:0]           offset;
    logic [7:0]           load_byte;
    logic [15:0]          load_half;
    logic [`LSU_XLEN-1:0] load_value;
    logic [3:0]           store_strb;
    logic [`LSU_XLEN-1:0] store_word;

    assign accept      = in_valid && in_ready;
    assign in_is_load  = in_data.op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    assign in_is_store = in_data.op inside {op_sb, op_sh, op_sw};

    // one item at a time, so ready simply follows the state
    assign in_ready  = (state == st_idle);
    assign out_valid = (state == st_hold);
    assign bready    = (state == st_wait_write);
    assign rready    = (state == st_wait_read);
    assign awvalid   = aw_pend;
    assign wvalid    = w_pend;
    assign arvalid   = ar_pend;

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= st_idle;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
            ar_pend <= 1'b0;
        end else begin
            if (awvalid && awready) aw_pend <= 1'b0;
            if (wvalid && wready)   w_pend  <= 1'b0;
            if (arvalid && arready) ar_pend <= 1'b0;

            case (state)
                st_idle: begin
                    if (accept) begin
                        if (in_is_load) begin
                            state   <= st_wait_read;
                            ar_pend <= 1'b1;
                        end else if (in_is_store) begin
                            state   <= st_wait_write;
                            aw_pend <= 1'b1;
                            w_pend  <= 1'b1;
                        end else begin
                            state <= st_hold;   // no bus access
                        end
                    end
                end
                st_wait_write: if (bvalid) state <= st_hold;
                st_wait_read:  if (rvalid) state <= st_hold;
                st_hold:       if (out_ready) state <= st_idle;
                default:       state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req      <= in_data;
            result_q <= '0;
            fault_q  <= 1'b0;
        end else if (bvalid && bready) begin
            fault_q <= (b.resp != `LSU_RESP_OKAY);
        end else if (rvalid && rready) begin
            result_q <= (r.resp == `LSU_RESP_OKAY) ? load_value : '0;
            fault_q  <= (r.resp != `LSU_RESP_OKAY);
        end
    end

    // load lane select and extension
    assign offset    = req.addr[1:0];
    assign load_byte = r.data[{offset, 3'b000} +: 8];
    assign load_half = r.data[{offset[1], 4'b0000} +: 16];

    always_comb begin
        case (req.op)
            op_lb:   load_value = {{(`LSU_XLEN-8){load_byte[7]}}, load_byte};
            op_lh:   load_value = {{(`LSU_XLEN-16){load_half[15]}}, load_half};
            op_lbu:  load_value = {{(`LSU_XLEN-8){1'b0}}, load_byte};
            op_lhu:  load_value = {{(`LSU_XLEN-16){1'b0}}, load_half};
            default: load_value = r.data;
        endcase
    end

    // store data is replicated on every lane, strobe picks the bytes
    always_comb begin
        case (req.op)
            op_sb: begin
                store_strb = 4'b0001 << offset;
                store_word = {4{req.store_data[7:0]}};
            end
            op_sh: begin
                store_strb = 4'b0011 << {offset[1], 1'b0};
                store_word = {2{req.store_data[15:0]}};
            end
            default: begin
                store_strb = 4'b1111;
                store_word = req.store_data;
            end
        endcase
    end

    assign aw.addr = req.addr;
    assign ar.addr = req.addr;
    assign w.data  = store_word;
    assign w.strb  = store_strb;

    assign out_data.pc        = req.pc;
    assign out_data.rd        = req.rd;
    assign out_data.reg_write = req.reg_write;
    assign out_data.result    = result_q;
    assign out_data.fault     = fault_q;

endmodule

//--- verilog/lsu_subsystem.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_subsystem
    import lsu_pkg::*;
(
    input  logic         clock,
    input  logic         reset,

    input  logic         in_valid,
    output logic         in_ready,
    input  exec_to_lsu_t in_data,

    output logic         out_valid,
    input  logic         out_ready,
    output lsu_to_wb_t   out_data
);

    logic                    awvalid;
    logic                    awready;
    axil_aw_t                aw;
    logic                    wvalid;
    logic                    wready;
    axil_w_t                 w;
    logic                    bvalid;
    logic                    bready;
    axil_b_t                 b;
    logic                    arvalid;
    logic                    arready;
    axil_ar_t                ar;
    logic                    rvalid;
    logic                    rready;
    axil_r_t                 r;

    lane_wr_t [3:0]          lane_wr;
    logic [`LSU_INDEX_W-1:0] rd_index;
    logic [3:0][7:0]         lane_data;

    lsu_stage u_stage (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .awvalid   (awvalid),
        .awready   (awready),
        .aw        (aw),
        .wvalid    (wvalid),
        .wready    (wready),
        .w         (w),
        .bvalid    (bvalid),
        .bready    (bready),
        .b         (b),
        .arvalid   (arvalid),
        .arready   (arready),
        .ar        (ar),
        .rvalid    (rvalid),
        .rready    (rready),
        .r         (r)
    );

    mem_write_port u_write_port (
        .clock   (clock),
        .reset   (reset),
        .awvalid (awvalid),
        .awready (awready),
        .aw      (aw),
        .wvalid  (wvalid),
        .wready  (wready),
        .w       (w),
        .bvalid  (bvalid),
        .bready  (bready),
        .b       (b),
        .lane_wr (lane_wr)
    );

    mem_read_port u_read_port (
        .clock     (clock),
        .reset     (reset),
        .arvalid   (arvalid),
        .arready   (arready),
        .ar        (ar),
        .rvalid    (rvalid),
        .rready    (rready),
        .r         (r),
        .rd_index  (rd_index),
        .lane_data (lane_data)
    );

    // byte lane i holds bits 8*i+7 downto 8*i of each word
    for (genvar i = 0; i < 4; i++) begin : g_lane
        mem_byte_lane u_lane (
            .clock    (clock),
            .wr       (lane_wr[i]),
            .rd_index (rd_index),
            .rd_byte  (lane_data[i])
        );
    end

endmodule

//--- bench/lsu_assertions.sv
`timescale 1ns/1ps

module lsu_assertions
    import lsu_pkg::*;
(
    input logic       clock,
    input logic       reset,
    input logic       awvalid,
    input logic       awready,
    input logic       wvalid,
    input logic       wready,
    input logic       arvalid,
    input logic       arready,
    input logic       out_valid,
    input logic       out_ready,
    input lsu_to_wb_t out_data
);

    property held_until_ready(logic valid, logic ready);
        @(posedge clock) disable iff (reset) valid && !ready |=> valid;
    endproperty

    aw_held: assert property (held_until_ready(awvalid, awready))
        else $error("awvalid dropped before awready");
    w_held: assert property (held_until_ready(wvalid, wready))
        else $error("wvalid dropped before wready");
    ar_held: assert property (held_until_ready(arvalid, arready))
        else $error("arvalid dropped before arready");

    // one transaction at a time
    no_dual_request: assert property (@(posedge clock) disable iff (reset)
        !(arvalid && awvalid))
        else $error("read and write requested in the same cycle");

    out_stable: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("output changed while waiting for out_ready");

endmodule

bind lsu_stage lsu_assertions u_assertions (
    .clock     (clock),
    .reset     (reset),
    .awvalid   (awvalid),
    .awready   (awready),
    .wvalid    (wvalid),
    .wready    (wready),
    .arvalid   (arvalid),
    .arready   (arready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;   // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

//--- bench/lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_tb
    import lsu_pkg::*;
();

    localparam int TIMEOUT   = 200;
    localparam int MEM_BYTES = `LSU_MEM_WORDS * 4;

    logic         clock;
    logic         reset;
    logic         in_valid;
    logic         in_ready;
    exec_to_lsu_t in_data;
    logic         out_valid;
    logic         out_ready;
    lsu_to_wb_t   out_data;

    exec_to_lsu_t case_in[$];
    lsu_to_wb_t   case_exp[$];
    logic [7:0]   model_mem [MEM_BYTES];
    int           value_errors;
    int           protocol_errors;
    int           timeouts;
    int           outputs_seen = 0;

    tb_clock_gen clock_gen (.clock(clock), .reset(reset));

    lsu_subsystem DUT (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    // every output handshake seen on the port
    always @(posedge clock) begin
        if (!reset && out_valid && out_ready) outputs_seen++;
    end

    function automatic mem_op_e op_from_text(input logic [63:0] text);
        case (text)
            "lb":    return op_lb;
            "lh":    return op_lh;
            "lw":    return op_lw;
            "lbu":   return op_lbu;
            "lhu":   return op_lhu;
            "sb":    return op_sb;
            "sh":    return op_sh;
            "sw":    return op_sw;
            default: return op_none;
        endcase
    endfunction

    task automatic read_cases();
        int            fd;
        logic [1023:0] line;
        logic [63:0]   op_text;
        logic [31:0]   addr;
        logic [31:0]   store_data;
        logic [31:0]   rd;
        logic [31:0]   result;
        logic [31:0]   fault;
        exec_to_lsu_t  c;
        lsu_to_wb_t    e;
        fd = $fopen("bench/lsu_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file");
            protocol_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%s %h %h %h %h %h", op_text, addr, store_data, rd,
                        result, fault) == 6) begin
                c.op = op_from_text(op_text);
                if (c.op == op_none && op_text != "none") begin
                    $display("unknown operation in the case file");
                    protocol_errors++;
                end
                c.pc         = 32'h0000_1000 + 4 * case_in.size();
                c.addr       = addr;
                c.store_data = store_data;
                c.rd         = rd[4:0];
                c.reg_write  = !(c.op inside {op_sb, op_sh, op_sw});
                e = '{pc: c.pc, rd: c.rd, reg_write: c.reg_write, result: result,
                      fault: fault[0]};
                case_in.push_back(c);
                case_exp.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // little-endian byte memory, word index wraps the same way as the banks
    task automatic model_apply(input exec_to_lsu_t c, output lsu_to_wb_t e);
        int          base;
        logic [31:0] word;
        logic [7:0]  bval;
        logic [15:0] hval;
        base = int'((c.addr >> 2) % `LSU_MEM_WORDS) * 4;
        word = {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1],
                model_mem[base]};
        bval = model_mem[base + c.addr[1:0]];
        hval = {model_mem[base + 2 * c.addr[1] + 1], model_mem[base + 2 * c.addr[1]]};
        e = '{pc: c.pc, rd: c.rd, reg_write: c.reg_write, result: '0, fault: 1'b0};
        if (c.op != op_none && (c.addr >> 2) >= `LSU_MEM_WORDS) begin
            e.fault = 1'b1;   // slave error, nothing written
        end else begin
            case (c.op)
                op_lb:  e.result = {{24{bval[7]}}, bval};
                op_lbu: e.result = {24'b0, bval};
                op_lh:  e.result = {{16{hval[15]}}, hval};
                op_lhu: e.result = {16'b0, hval};
                op_lw:  e.result = word;
                op_sb:  model_mem[base + c.addr[1:0]] = c.store_data[7:0];
                op_sh: begin
                    model_mem[base + 2 * c.addr[1]]     = c.store_data[7:0];
                    model_mem[base + 2 * c.addr[1] + 1] = c.store_data[15:8];
                end
                op_sw: begin
                    for (int k = 0; k < 4; k++) model_mem[base + k] = c.store_data[8*k +: 8];
                end
                default: ;
            endcase
        end
    endtask

    task automatic compare_wb(input string name, input lsu_to_wb_t exp, input lsu_to_wb_t act);
        string exp_text;
        string act_text;
        exp_text = $sformatf("pc %h rd %0d wr %b result %h", exp.pc, exp.rd, exp.reg_write,
                             exp.result);
        act_text = $sformatf("pc %h rd %0d wr %b result %h", act.pc, act.rd, act.reg_write,
                             act.result);
        if (act.result !== exp.result || act.rd !== exp.rd || act.pc !== exp.pc ||
            act.reg_write !== exp.reg_write) begin
            $display("FAILED %s: expected %s, actual %s", name, exp_text, act_text);
            value_errors++;
        end
    endtask

    task automatic compare_fault(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected fault %b actual fault %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic run_case(input int i);
        exec_to_lsu_t c;
        lsu_to_wb_t   e;
        lsu_to_wb_t   held;
        string        name;
        int           cycles;
        int           first_valid;
        logic         taken;
        c = case_in[i];
        model_apply(c, e);
        name = $sformatf("case %0d %s", i, c.op.name());
        if (e.result !== case_exp[i].result || e.fault !== case_exp[i].fault) begin
            $display("%s: case file and reference model disagree", name);
            protocol_errors++;
        end
        in_valid = 1'b1;
        in_data  = c;
        cycles   = 0;
        while (!in_ready && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!in_ready) begin
            $display("%s: timed out waiting for in_ready", name);
            timeouts++;
            return;
        end
        @(negedge clock);   // accepted at the edge just passed
        in_valid    = 1'b0;
        cycles      = 1;
        first_valid = 0;
        taken       = 1'b0;
        while (!taken && cycles <= TIMEOUT) begin
            out_ready = ($urandom % 3) != 0;
            if (in_ready) begin
                $display("%s: in_ready high before the output was taken", name);
                protocol_errors++;
            end
            if (out_valid) begin
                if (first_valid == 0) begin
                    first_valid = cycles;
                    held        = out_data;
                end else if (out_data !== held) begin
                    $display("%s: out_data changed while out_valid waited", name);
                    protocol_errors++;
                end
                taken = out_ready;
            end
            @(negedge clock);
            cycles++;
        end
        if (!taken) begin
            $display("%s: timed out waiting for the output", name);
            timeouts++;
            return;
        end
        compare_wb(name, e, held);
        compare_fault(name, e.fault, held.fault);
        if ((c.op == op_none && first_valid != 1) || (c.op != op_none && first_valid < 4)) begin
            $display("%s: output arrived after %0d cycles", name, first_valid);
            protocol_errors++;
        end
        if (!in_ready || out_valid) begin
            $display("%s: stage not idle in the cycle after the handshake", name);
            protocol_errors++;
        end
    endtask

    initial begin
        int unsigned seed;
        int          cycles;
        seed            = 32'h5220;
        void'($urandom(seed));
        in_valid        = 1'b0;
        in_data         = '0;
        out_ready       = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        read_cases();
        if (case_in.size() == 0) begin
            $display("no cases were read");
            protocol_errors++;
        end
        cycles = 0;
        @(negedge clock);
        while (reset && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (reset) begin
            $display("reset never released");
            timeouts++;
        end
        for (int i = 0; i < case_in.size() && timeouts == 0; i++) run_case(i);
        if (outputs_seen != case_in.size()) begin
            $display("output count %0d does not match case count %0d",
                     outputs_seen, case_in.size());
            protocol_errors++;
        end
        $display("errors: value %0d protocol %0d timeout %0d, outputs %0d of %0d",
                 value_errors, protocol_errors, timeouts, outputs_seen, case_in.size());
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- bench/lsu_cases.txt
# op addr store_data rd expected_result expected_fault
# values are hex, stores and none expect result zero
sw   00000000 0badf00d 00 00000000 0
sw   00000010 deadbeef 01 00000000 0
lw   00000010 00000000 02 deadbeef 0
sw   00000020 11223344 03 00000000 0
sb   00000021 000000a5 00 00000000 0
lw   00000020 00000000 04 1122a544 0
sh   00000022 0000beef 00 00000000 0
lw   00000020 00000000 05 beefa544 0
sw   00000030 80ff7f01 00 00000000 0
lb   00000030 00000000 06 00000001 0
lb   00000031 00000000 07 0000007f 0
lb   00000032 00000000 08 ffffffff 0
lb   00000033 00000000 09 ffffff80 0
lbu  00000030 00000000 0a 00000001 0
lbu  00000031 00000000 0b 0000007f 0
lbu  00000032 00000000 0c 000000ff 0
lbu  00000033 00000000 0d 00000080 0
lh   00000030 00000000 0e 00007f01 0
lh   00000032 00000000 0f ffff80ff 0
lhu  00000030 00000000 10 00007f01 0
lhu  00000032 00000000 11 000080ff 0
none 00000044 12345678 12 00000000 0
sw   00000400 cafef00d 13 00000000 1
lw   00000400 00000000 14 00000000 1
lw   00000000 00000000 15 0badf00d 0
none 00000000 00000000 16 00000000 0

//--- filelist.f
+incdir+common
common/lsu_pkg.sv
mem/mem_byte_lane.sv
mem/mem_write_port.sv
mem/mem_read_port.sv
lsu/lsu_stage.sv
verilog/lsu_subsystem.sv
bench/lsu_assertions.sv
bench/tb_clock_gen.sv
bench/lsu_tb.sv
